//--- tb.f
verilog/cache_pkg.sv
verilog/line_sweep.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/bank_ctrl.sv
verilog/cache_bank.sv
verification/mem_model.sv
verification/tb_cache_bank.sv

//--- Makefile
SIM = obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module tb_cache_bank -o sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_cache_bank.sv
`default_nettype none

module tb_cache_bank import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 20;
    // rough length of all six tests in clock cycles
    localparam int TEST_CYCLES = 6 * 80;

    logic                       clk;
    logic                       rst_n;
    logic                       core_req_valid;
    logic [LINE_ADDR_WIDTH-1:0] core_req_addr;
    logic                       core_req_rw;
    logic [WORD_SEL_BITS-1:0]   core_req_wsel;
    logic [WORD_SIZE-1:0]       core_req_byteen;
    logic [WORD_WIDTH-1:0]      core_req_data;
    logic [REQ_TAG_WIDTH-1:0]   core_req_tag;
    logic                       core_req_ready;
    logic                       core_rsp_valid;
    logic [WORD_WIDTH-1:0]      core_rsp_data;
    logic [REQ_TAG_WIDTH-1:0]   core_rsp_tag;
    logic                       core_rsp_ready;
    logic                       mem_req_valid;
    logic                       mem_req_rw;
    logic [LINE_ADDR_WIDTH-1:0] mem_req_addr;
    logic [LINE_SIZE-1:0]       mem_req_byteen;
    logic [LINE_WIDTH-1:0]      mem_req_data;
    logic                       mem_req_ready;
    logic                       mem_rsp_valid;
    logic [LINE_WIDTH-1:0]      mem_rsp_data;
    logic                       mem_rsp_ready;
    logic                       flush_begin;
    logic                       flush_end;

    cache_bank i_cache_bank (.*);

    mem_model i_mem_model (
        .clk            (clk),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    // initial memory word built from its line address and word index
    function automatic logic [WORD_WIDTH-1:0] expected_pattern(int unsigned a, int unsigned w);
        return 32'hC0DE0000 | WORD_WIDTH'(a * 4 + w);
    endfunction

    function automatic logic [WORD_WIDTH-1:0] merge_bytes(logic [WORD_WIDTH-1:0] old_word,
                                                         logic [WORD_WIDTH-1:0] new_word,
                                                         logic [WORD_SIZE-1:0] byteen);
        logic [WORD_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < WORD_SIZE; b++) begin
            if (byteen[b]) begin
                result[b * 8 +: 8] = new_word[b * 8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic check(string name, logic [LINE_WIDTH-1:0] expected,
                         logic [LINE_WIDTH-1:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic send_req(logic [LINE_ADDR_WIDTH-1:0] addr, logic rw,
                            logic [WORD_SEL_BITS-1:0] wsel, logic [WORD_SIZE-1:0] byteen,
                            logic [WORD_WIDTH-1:0] data, logic [REQ_TAG_WIDTH-1:0] tag);
        logic accepted;
        core_req_valid  = 1'b1;
        core_req_addr   = addr;
        core_req_rw     = rw;
        core_req_wsel   = wsel;
        core_req_byteen = byteen;
        core_req_data   = data;
        core_req_tag    = tag;
        do begin
            accepted = core_req_ready;
            @(posedge clk);
        end while (!accepted);
        #2;
        core_req_valid = 1'b0;
    endtask

    task automatic read_and_check(string name, logic [LINE_ADDR_WIDTH-1:0] addr,
                                  logic [WORD_SEL_BITS-1:0] wsel,
                                  logic [REQ_TAG_WIDTH-1:0] tag,
                                  logic [WORD_WIDTH-1:0] expected, logic expect_hit, int hold);
        int reads_before;
        int n;
        reads_before = i_mem_model.read_count;
        send_req(addr, 1'b0, wsel, '1, '0, tag);
        n = 0;
        while (!core_rsp_valid) begin
            @(posedge clk);
            #2;
            n++;
        end
        // a hit spends one cycle in lookup before responding
        if (expect_hit) begin
            check({name, " hit latency"}, LINE_WIDTH'(1), LINE_WIDTH'(n));
        end
        repeat (hold) begin
            check({name, " held data"}, LINE_WIDTH'(expected), LINE_WIDTH'(core_rsp_data));
            @(posedge clk);
            #2;
            check({name, " held valid"}, LINE_WIDTH'(1), LINE_WIDTH'(core_rsp_valid));
        end
        check({name, " data"}, LINE_WIDTH'(expected), LINE_WIDTH'(core_rsp_data));
        check({name, " tag"}, LINE_WIDTH'(tag), LINE_WIDTH'(core_rsp_tag));
        core_rsp_ready = 1'b1;
        @(posedge clk);
        #2;
        core_rsp_ready = 1'b0;
        check({name, " memory reads"}, LINE_WIDTH'(reads_before + (expect_hit ? 0 : 1)),
              LINE_WIDTH'(i_mem_model.read_count));
        if (!expect_hit) begin
            check({name, " read address"}, LINE_WIDTH'(addr),
                  LINE_WIDTH'(i_mem_model.last_rd_addr));
        end
    endtask

    task automatic write_and_check(string name, logic [LINE_ADDR_WIDTH-1:0] addr,
                                   logic [WORD_SEL_BITS-1:0] wsel,
                                   logic [WORD_SIZE-1:0] byteen, logic [WORD_WIDTH-1:0] data);
        logic [LINE_SIZE-1:0]  exp_byteen;
        logic [LINE_WIDTH-1:0] exp_data;
        int                    writes_before;
        // write word in every slot and byte enables only in the selected one
        exp_byteen = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp_data[w * WORD_WIDTH +: WORD_WIDTH] = data;
            if (w == int'(wsel)) begin
                exp_byteen[w * WORD_SIZE +: WORD_SIZE] = byteen;
            end
        end
        writes_before = i_mem_model.write_count;
        send_req(addr, 1'b1, wsel, byteen, data, '0);
        while (!core_req_ready) begin
            @(posedge clk);
            #2;
        end
        check({name, " memory writes"}, LINE_WIDTH'(writes_before + 1),
              LINE_WIDTH'(i_mem_model.write_count));
        check({name, " write address"}, LINE_WIDTH'(addr), LINE_WIDTH'(i_mem_model.last_wr_addr));
        check({name, " write data"}, exp_data, i_mem_model.last_wr_data);
        check({name, " write byteen"}, LINE_WIDTH'(exp_byteen),
              LINE_WIDTH'(i_mem_model.last_wr_byteen));
    endtask

    task automatic test_reset_sweep();
        int n;
        n = 0;
        while (!core_req_ready) begin
            @(posedge clk);
            #2;
            n++;
        end
        check("reset_sweep ready delay", LINE_WIDTH'(NUM_LINES), LINE_WIDTH'(n));
        read_and_check("reset_sweep", 10'h023, 2'd1, 4'h3, expected_pattern('h23, 1), 1'b0, 0);
    endtask

    task automatic test_read_hit();
        read_and_check("read_hit", 10'h023, 2'd1, 4'h5, expected_pattern('h23, 1), 1'b1, 3);
    endtask

    task automatic test_write_through();
        logic [WORD_WIDTH-1:0] merged;
        merged = merge_bytes(expected_pattern('h23, 1), 32'h11223344, 4'b0101);
        write_and_check("write_through", 10'h023, 2'd1, 4'b0101, 32'h11223344);
        read_and_check("write_through", 10'h023, 2'd1, 4'h6, merged, 1'b1, 0);
    endtask

    task automatic test_write_miss();
        logic [WORD_WIDTH-1:0] merged;
        merged = merge_bytes(expected_pattern('h57, 2), 32'hAABBCCDD, 4'b1100);
        write_and_check("write_miss", 10'h057, 2'd2, 4'b1100, 32'hAABBCCDD);
        read_and_check("write_miss", 10'h057, 2'd2, 4'h7, merged, 1'b0, 0);
    endtask

    task automatic test_conflict();
        // same index 5, tags 0x0a and 0x1a
        read_and_check("conflict a", 10'h0A5, 2'd0, 4'h1, expected_pattern('h0A5, 0), 1'b0, 0);
        read_and_check("conflict b", 10'h1A5, 2'd3, 4'h2, expected_pattern('h1A5, 3), 1'b0, 0);
        read_and_check("conflict a again", 10'h0A5, 2'd0, 4'h3,
                       expected_pattern('h0A5, 0), 1'b0, 0);
    endtask

    task automatic test_flush();
        int n;
        read_and_check("flush fill", 10'h0C9, 2'd2, 4'h8, expected_pattern('h0C9, 2), 1'b0, 0);
        read_and_check("flush hit", 10'h0C9, 2'd2, 4'h9, expected_pattern('h0C9, 2), 1'b1, 0);
        while (!core_req_ready) begin
            @(posedge clk);
            #2;
        end
        flush_begin = 1'b1;
        @(posedge clk);
        #2;
        flush_begin = 1'b0;
        n = 1;
        while (!flush_end) begin
            @(posedge clk);
            #2;
            n++;
        end
        check("flush end delay", LINE_WIDTH'(NUM_LINES + 1), LINE_WIDTH'(n));
        @(posedge clk);
        #2;
        check("flush end pulse width", LINE_WIDTH'(0), LINE_WIDTH'(flush_end));
        read_and_check("flush miss", 10'h0C9, 2'd2, 4'hA, expected_pattern('h0C9, 2), 1'b0, 0);
    endtask

    initial begin
        void'($urandom(24930));
        rst_n           = 1'b0;
        core_req_valid  = 1'b0;
        core_req_addr   = '0;
        core_req_rw     = 1'b0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        flush_begin     = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_sweep();
        test_read_hit();
        test_write_through();
        test_write_miss();
        test_conflict();
        test_flush();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`default_nettype none

module mem_model import cache_pkg::*; (
    input  wire                        clk,
    input  wire                        mem_req_valid,
    input  wire                        mem_req_rw,
    input  wire  [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    input  wire  [LINE_SIZE-1:0]       mem_req_byteen,
    input  wire  [LINE_WIDTH-1:0]      mem_req_data,
    output logic                       mem_req_ready,
    output logic                       mem_rsp_valid,
    output logic [LINE_WIDTH-1:0]      mem_rsp_data,
    input  wire                        mem_rsp_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [LINE_WIDTH-1:0]      lines [1 << LINE_ADDR_WIDTH];
    int                         read_count;
    int                         write_count;
    logic [LINE_ADDR_WIDTH-1:0] last_rd_addr;
    logic [LINE_ADDR_WIDTH-1:0] last_wr_addr;
    logic [LINE_SIZE-1:0]       last_wr_byteen;
    logic [LINE_WIDTH-1:0]      last_wr_data;

    // each word carries its full line address and word index
    function automatic logic [WORD_WIDTH-1:0] word_pattern(int unsigned a, int unsigned w);
        return 32'hC0DE0000 | WORD_WIDTH'(a * 4 + w);
    endfunction

    initial begin
        for (int a = 0; a < (1 << LINE_ADDR_WIDTH); a++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                lines[a][w * WORD_WIDTH +: WORD_WIDTH] = word_pattern(a, w);
            end
        end
    end

    initial begin
        logic                       done;
        logic                       is_write;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        read_count    = 0;
        write_count   = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_req_valid) begin
                repeat ($urandom_range(0, 3)) @(posedge clk);
                #2;
                mem_req_ready = 1'b1;
                is_write = mem_req_rw;
                addr     = mem_req_addr;
                if (is_write) begin
                    for (int b = 0; b < LINE_SIZE; b++) begin
                        if (mem_req_byteen[b]) begin
                            lines[addr][b * 8 +: 8] = mem_req_data[b * 8 +: 8];
                        end
                    end
                    last_wr_addr   = addr;
                    last_wr_byteen = mem_req_byteen;
                    last_wr_data   = mem_req_data;
                    write_count++;
                end else begin
                    last_rd_addr = addr;
                    read_count++;
                end
                @(posedge clk);
                #2;
                mem_req_ready = 1'b0;
                if (!is_write) begin
                    repeat ($urandom_range(0, 3)) @(posedge clk);
                    #2;
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = lines[addr];
                    // ready is sampled mid-cycle, the transfer is the next edge
                    do begin
                        done = mem_rsp_ready;
                        @(posedge clk);
                    end while (!done);
                    #2;
                    mem_rsp_valid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_bank.sv
`default_nettype none

module cache_bank import cache_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        core_req_valid,
    input  wire  [LINE_ADDR_WIDTH-1:0] core_req_addr,
    input  wire                        core_req_rw,
    input  wire  [WORD_SEL_BITS-1:0]   core_req_wsel,
    input  wire  [WORD_SIZE-1:0]       core_req_byteen,
    input  wire  [WORD_WIDTH-1:0]      core_req_data,
    input  wire  [REQ_TAG_WIDTH-1:0]   core_req_tag,
    output logic                       core_req_ready,

    output logic                       core_rsp_valid,
    output logic [WORD_WIDTH-1:0]      core_rsp_data,
    output logic [REQ_TAG_WIDTH-1:0]   core_rsp_tag,
    input  wire                        core_rsp_ready,

    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [LINE_SIZE-1:0]       mem_req_byteen,
    output logic [LINE_WIDTH-1:0]      mem_req_data,
    input  wire                        mem_req_ready,

    input  wire                        mem_rsp_valid,
    input  wire  [LINE_WIDTH-1:0]      mem_rsp_data,
    output logic                       mem_rsp_ready,

    input  wire                        flush_begin,
    output logic                       flush_end
);

    logic                     sweep_start;
    logic                     sweep_busy;
    logic                     sweep_done;
    logic [LINE_SEL_BITS-1:0] sweep_line;

    logic [LINE_SEL_BITS-1:0] store_index;
    logic [TAG_BITS-1:0]      store_tag;
    logic [WORD_SEL_BITS-1:0] store_wsel;
    logic                     tag_fill;
    logic                     data_fill;
    logic                     data_write;
    logic [WORD_SIZE-1:0]     write_byteen;
    logic [WORD_WIDTH-1:0]    write_word;
    logic                     hit;
    logic [WORD_WIDTH-1:0]    read_word;

    // shared by the reset sweep and flush
    line_sweep i_line_sweep (
        .clk   (clk),
        .rst_n (rst_n),
        .start (sweep_start),
        .busy  (sweep_busy),
        .line  (sweep_line),
        .done  (sweep_done)
    );

    tag_store i_tag_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (store_index),
        .lookup_tag (store_tag),
        .fill       (tag_fill),
        .clear      (sweep_busy),
        .clear_line (sweep_line),
        .hit        (hit)
    );

    data_store i_data_store (
        .clk          (clk),
        .index        (store_index),
        .wsel         (store_wsel),
        .fill         (data_fill),
        .fill_data    (mem_rsp_data),
        .write        (data_write),
        .write_byteen (write_byteen),
        .write_word   (write_word),
        .read_word    (read_word)
    );

    bank_ctrl i_bank_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_addr   (core_req_addr),
        .core_req_rw     (core_req_rw),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req_valid   (mem_req_valid),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready),
        .flush_begin     (flush_begin),
        .flush_end       (flush_end),
        .sweep_busy      (sweep_busy),
        .sweep_done      (sweep_done),
        .sweep_start     (sweep_start),
        .store_index     (store_index),
        .store_tag       (store_tag),
        .store_wsel      (store_wsel),
        .tag_fill        (tag_fill),
        .data_fill       (data_fill),
        .data_write      (data_write),
        .write_byteen    (write_byteen),
        .write_word      (write_word),
        .hit             (hit),
        .read_word       (read_word)
    );

endmodule

`default_nettype wire

//--- verilog/bank_ctrl.sv
`default_nettype none

module bank_ctrl import cache_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        core_req_valid,
    input  wire  [LINE_ADDR_WIDTH-1:0] core_req_addr,
    input  wire                        core_req_rw,
    input  wire  [WORD_SEL_BITS-1:0]   core_req_wsel,
    input  wire  [WORD_SIZE-1:0]       core_req_byteen,
    input  wire  [WORD_WIDTH-1:0]      core_req_data,
    input  wire  [REQ_TAG_WIDTH-1:0]   core_req_tag,
    output logic                       core_req_ready,

    output logic                       core_rsp_valid,
    output logic [WORD_WIDTH-1:0]      core_rsp_data,
    output logic [REQ_TAG_WIDTH-1:0]   core_rsp_tag,
    input  wire                        core_rsp_ready,

    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [LINE_SIZE-1:0]       mem_req_byteen,
    output logic [LINE_WIDTH-1:0]      mem_req_data,
    input  wire                        mem_req_ready,

    input  wire                        mem_rsp_valid,
    input  wire  [LINE_WIDTH-1:0]      mem_rsp_data,
    output logic                       mem_rsp_ready,

    input  wire                        flush_begin,
    output logic                       flush_end,

    input  wire                        sweep_busy,
    input  wire                        sweep_done,
    output logic                       sweep_start,

    output logic [LINE_SEL_BITS-1:0]   store_index,
    output logic [TAG_BITS-1:0]        store_tag,
    output logic [WORD_SEL_BITS-1:0]   store_wsel,
    output logic                       tag_fill,
    output logic                       data_fill,
    output logic                       data_write,
    output logic [WORD_SIZE-1:0]       write_byteen,
    output logic [WORD_WIDTH-1:0]      write_word,
    input  wire                        hit,
    input  wire  [WORD_WIDTH-1:0]      read_word
);

    bank_state_e state;
    mem_op_e     mem_op;

    // the one request in flight
    logic [LINE_ADDR_WIDTH-1:0] req_addr;
    logic                       req_rw;
    logic [WORD_SEL_BITS-1:0]   req_wsel;
    logic [WORD_SIZE-1:0]       req_byteen;
    logic [WORD_WIDTH-1:0]      req_data;
    logic [REQ_TAG_WIDTH-1:0]   req_tag;
    logic [WORD_WIDTH-1:0]      rsp_data;

    logic core_req_fire;
    logic fill_fire;

    // flush wins over a core request in the same cycle
    assign core_req_ready = (state == ST_IDLE) && !flush_begin && !sweep_busy;
    assign core_req_fire  = core_req_valid && core_req_ready;
    assign sweep_start    = (state == ST_IDLE) && flush_begin;
    assign mem_rsp_ready  = (state == ST_FILL_WAIT);
    assign fill_fire      = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_INIT;
            flush_end <= 1'b0;
        end else begin
            flush_end <= 1'b0;
            case (state)
                ST_INIT:      if (sweep_done) state <= ST_IDLE;
                ST_IDLE: begin
                    if (sweep_start) begin
                        state <= ST_FLUSH;
                    end else if (core_req_fire) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (req_rw) begin
                        state <= ST_WRITE_REQ;
                    end else if (hit) begin
                        state <= ST_RESPOND;
                    end else begin
                        state <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ:  if (mem_req_ready) state <= ST_FILL_WAIT;
                ST_FILL_WAIT: if (fill_fire) state <= ST_RESPOND;
                ST_WRITE_REQ: if (mem_req_ready) state <= ST_IDLE;
                ST_RESPOND:   if (core_rsp_ready) state <= ST_IDLE;
                ST_FLUSH: begin
                    if (sweep_done) begin
                        state     <= ST_IDLE;
                        flush_end <= 1'b1;
                    end
                end
                default:      state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (core_req_fire) begin
            req_addr   <= core_req_addr;
            req_rw     <= core_req_rw;
            req_wsel   <= core_req_wsel;
            req_byteen <= core_req_byteen;
            req_data   <= core_req_data;
            req_tag    <= core_req_tag;
        end
        // hit data comes from the store, miss data straight from the fill line
        if (state == ST_LOOKUP) begin
            rsp_data <= read_word;
        end else if (fill_fire) begin
            rsp_data <= mem_rsp_data[req_wsel * WORD_WIDTH +: WORD_WIDTH];
        end
    end

    assign store_index  = req_addr[LINE_SEL_BITS-1:0];
    assign store_tag    = req_addr[LINE_ADDR_WIDTH-1 -: TAG_BITS];
    assign store_wsel   = req_wsel;
    assign tag_fill     = fill_fire;
    assign data_fill    = fill_fire;
    // write hits merge into the stored line, misses do not allocate
    assign data_write   = (state == ST_LOOKUP) && req_rw && hit;
    assign write_byteen = req_byteen;
    assign write_word   = req_data;

    assign mem_op         = (state == ST_WRITE_REQ) ? MEM_WRITE : MEM_READ;
    assign mem_req_valid  = (state == ST_FILL_REQ) || (state == ST_WRITE_REQ);
    assign mem_req_rw     = mem_op;
    assign mem_req_addr   = req_addr;
    assign mem_req_data   = {WORDS_PER_LINE{req_data}};
    assign mem_req_byteen = (mem_op == MEM_WRITE) ?
                            (LINE_SIZE'(req_byteen) << (req_wsel * WORD_SIZE)) : '1;

    assign core_rsp_valid = (state == ST_RESPOND);
    assign core_rsp_data  = rsp_data;
    assign core_rsp_tag   = req_tag;

endmodule

`default_nettype wire

//--- verilog/data_store.sv
`default_nettype none

module data_store import cache_pkg::*; (
    input  wire                      clk,
    input  wire  [LINE_SEL_BITS-1:0] index,
    input  wire  [WORD_SEL_BITS-1:0] wsel,
    input  wire                      fill,
    input  wire  [LINE_WIDTH-1:0]    fill_data,
    input  wire                      write,
    input  wire  [WORD_SIZE-1:0]     write_byteen,
    input  wire  [WORD_WIDTH-1:0]    write_word,
    output logic [WORD_WIDTH-1:0]    read_word
);

    logic [LINE_WIDTH-1:0] lines [NUM_LINES];
    logic [LINE_WIDTH-1:0] merged_line;

    // merge the enabled bytes of the write word into the selected word
    always_comb begin
        merged_line = lines[index];
        for (int b = 0; b < WORD_SIZE; b++) begin
            if (write_byteen[b]) begin
                merged_line[wsel * WORD_WIDTH + b * 8 +: 8] = write_word[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[index] <= fill_data;
        end else if (write) begin
            lines[index] <= merged_line;
        end
    end

    // word read is combinational
    assign read_word = lines[index][wsel * WORD_WIDTH +: WORD_WIDTH];

endmodule

`default_nettype wire

//--- verilog/tag_store.sv
`default_nettype none

module tag_store import cache_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire  [LINE_SEL_BITS-1:0] index,
    input  wire  [TAG_BITS-1:0]      lookup_tag,
    input  wire                      fill,
    input  wire                      clear,
    input  wire  [LINE_SEL_BITS-1:0] clear_line,
    output logic                     hit
);

    logic [NUM_LINES-1:0] valid;
    logic [TAG_BITS-1:0]  tags [NUM_LINES];

    // valid bits per line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (clear) begin
                valid[clear_line] <= 1'b0;
            end
            if (fill) begin
                valid[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index] <= lookup_tag;
        end
    end

    // direct mapped, so a single compare decides the hit
    assign hit = valid[index] && (tags[index] == lookup_tag);

endmodule

`default_nettype wire

//--- verilog/line_sweep.sv
`default_nettype none

module line_sweep import cache_pkg::*; (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    output logic                     busy,
    output logic [LINE_SEL_BITS-1:0] line,
    output logic                     done
);

    localparam logic [LINE_SEL_BITS-1:0] LAST_LINE = LINE_SEL_BITS'(NUM_LINES - 1);

    // out of reset the sweep is already running from line 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b1;
            line <= '0;
        end else if (start) begin
            busy <= 1'b1;
            line <= '0;
        end else if (busy) begin
            if (line == LAST_LINE) begin
                busy <= 1'b0;
            end
            // wraps back to 0 after the last line
            line <= line + 1'b1;
        end
    end

    // high during the cycle that clears the last line
    assign done = busy && (line == LAST_LINE);

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // line address splits into tag (high bits) and line index (low bits)
    localparam int LINE_ADDR_WIDTH = 10;
    localparam int LINE_SEL_BITS   = 4;
    localparam int NUM_LINES       = 1 << LINE_SEL_BITS;
    localparam int TAG_BITS        = LINE_ADDR_WIDTH - LINE_SEL_BITS;

    localparam int WORD_SIZE       = 4;
    localparam int WORD_WIDTH      = 8 * WORD_SIZE;
    localparam int WORDS_PER_LINE  = 4;
    localparam int WORD_SEL_BITS   = $clog2(WORDS_PER_LINE);
    localparam int LINE_SIZE       = WORD_SIZE * WORDS_PER_LINE;
    localparam int LINE_WIDTH      = 8 * LINE_SIZE;

    localparam int REQ_TAG_WIDTH   = 4;

    typedef enum logic [2:0] {
        ST_INIT,        // reset sweep in progress
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_WRITE_REQ,
        ST_RESPOND,
        ST_FLUSH
    } bank_state_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire
